/* Bender.yml */
package:
  name: csr_sys

sources:
  # packages first, then the pipeline stages and the top level
  - rv_isa_pkg.sv
  - rv_trap_pkg.sv
  - sys_decode.sv
  - csr_file.sv
  - trap_redirect.sv
  - csr_sys_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - csr_sys_chk.sv
      - tb_csr_sys.sv

/* csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
    parameter int unsigned XLEN = rv_isa_pkg::XLEN_DEFAULT
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     stall_n_i,
    input  wire                     valid_i,
    input  wire rv_isa_pkg::csr_op_e op_i,
    input  wire  [11:0]             addr_i,
    input  wire  [XLEN-1:0]         wdata_i,
    input  wire  [XLEN-1:0]         pc_i,
    input  wire                     ecall_i,
    input  wire                     mret_i,
    input  wire                     timer_int_i,
    output logic [XLEN-1:0]         csr_rdata_o,
    output logic                    rdata_valid_o,
    output logic                    trap_take_o,
    output logic                    mret_take_o,
    output logic [XLEN-1:0]         mtvec_o,
    output logic [XLEN-1:0]         mepc_o
);

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;
    logic [XLEN-1:0] trap_cause;
    logic            irq_pending;
    logic            csr_en;
    logic            timer_set;

    // timer interrupt beats whatever instruction sits in this stage
    assign irq_pending = mip[rv_trap_pkg::MIP_MTIP_BIT] && mstatus[rv_trap_pkg::MSTATUS_MIE_BIT];
    assign trap_take_o = irq_pending || (valid_i && ecall_i);
    assign mret_take_o = valid_i && mret_i && !irq_pending;
    assign csr_en      = valid_i && (op_i != rv_isa_pkg::CSR_OP_NONE) && !irq_pending;

    assign timer_set = timer_int_i && mie[rv_trap_pkg::MIE_MTIE_BIT]
                       && mstatus[rv_trap_pkg::MSTATUS_MIE_BIT];

    assign trap_cause = irq_pending ? {1'b1, (XLEN-1)'(rv_trap_pkg::CAUSE_TIMER_M)}
                                    : XLEN'(rv_trap_pkg::CAUSE_ECALL_M);

    // unknown addresses read as zero
    always_comb begin
        case (addr_i)
            rv_isa_pkg::CSR_MSTATUS: old_val = mstatus;
            rv_isa_pkg::CSR_MIE:     old_val = mie;
            rv_isa_pkg::CSR_MIP:     old_val = mip;
            rv_isa_pkg::CSR_MTVEC:   old_val = mtvec;
            rv_isa_pkg::CSR_MEPC:    old_val = mepc;
            rv_isa_pkg::CSR_MCAUSE:  old_val = mcause;
            default:                 old_val = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            rv_isa_pkg::CSR_OP_WRITE: new_val = wdata_i;
            rv_isa_pkg::CSR_OP_SET:   new_val = old_val | wdata_i;
            rv_isa_pkg::CSR_OP_CLEAR: new_val = old_val & ~wdata_i;
            default:                  new_val = old_val;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus <= XLEN'(rv_trap_pkg::MSTATUS_RESET);
            mie     <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (stall_n_i) begin
            if (trap_take_o) begin
                mepc   <= {pc_i[XLEN-1:2], 2'b00};
                mcause <= trap_cause;
                mstatus[rv_trap_pkg::MSTATUS_MPIE_BIT]    <= mstatus[rv_trap_pkg::MSTATUS_MIE_BIT];
                mstatus[rv_trap_pkg::MSTATUS_MIE_BIT]     <= 1'b0;
                mstatus[rv_trap_pkg::MSTATUS_MPP_LSB +: 2] <= 2'b11;
            end else if (mret_take_o) begin
                mstatus[rv_trap_pkg::MSTATUS_MIE_BIT]  <= mstatus[rv_trap_pkg::MSTATUS_MPIE_BIT];
                mstatus[rv_trap_pkg::MSTATUS_MPIE_BIT] <= 1'b1;
            end else if (csr_en) begin
                // vector and return address stay word aligned
                case (addr_i)
                    rv_isa_pkg::CSR_MSTATUS: mstatus <= new_val;
                    rv_isa_pkg::CSR_MIE:     mie     <= new_val;
                    rv_isa_pkg::CSR_MTVEC:   mtvec   <= {new_val[XLEN-1:2], 2'b00};
                    rv_isa_pkg::CSR_MEPC:    mepc    <= {new_val[XLEN-1:2], 2'b00};
                    rv_isa_pkg::CSR_MCAUSE:  mcause  <= new_val;
                    default: begin
                    end
                endcase
            end
        end
    end

    // the timer pulse is one cycle wide, so it is latched even while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mip <= '0;
        end else begin
            if (stall_n_i && csr_en && (addr_i == rv_isa_pkg::CSR_MIP)) begin
                mip <= new_val;
            end
            if (timer_set) begin
                mip[rv_trap_pkg::MIP_MTIP_BIT] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid_o <= 1'b0;
        end else begin
            rdata_valid_o <= stall_n_i && csr_en;
        end
    end

    // old value goes back, whatever the op
    always_ff @(posedge clk) begin
        if (stall_n_i && csr_en) begin
            csr_rdata_o <= old_val;
        end
    end

    assign mtvec_o = mtvec;
    assign mepc_o  = mepc;

endmodule

`default_nettype wire

/* csr_sys_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_sys_chk #(
    parameter int unsigned XLEN = rv_isa_pkg::XLEN_DEFAULT
) (
    input wire            clk,
    input wire            rst_n,
    input wire            stall_n_i,
    input wire            rdata_valid_i,
    input wire            redirect_i,
    input wire [XLEN-1:0] redirect_pc_i
);

    // redirect is a single cycle pulse
    redirect_single: assert property (
        @(posedge clk) disable iff (!rst_n) redirect_i |=> !redirect_i
    ) else $error("redirect_o high for two cycles in a row");

    redirect_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) redirect_i |-> (redirect_pc_i[1:0] == 2'b00)
    ) else $error("redirect_pc_o not word aligned");

    quiet_in_reset: assert property (
        @(posedge clk) !rst_n |=> (!rdata_valid_i && !redirect_i)
    ) else $error("pulse output high during reset");

    // a stalled edge never produces a pulse
    quiet_after_stall: assert property (
        @(posedge clk) disable iff (!rst_n) !stall_n_i |=> (!rdata_valid_i && !redirect_i)
    ) else $error("pulse output high after a stalled edge");

endmodule

bind csr_sys_top csr_sys_chk #(
    .XLEN (XLEN)
) chk_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_n_i     (stall_n_i),
    .rdata_valid_i (rdata_valid_o),
    .redirect_i    (redirect_o),
    .redirect_pc_i (redirect_pc_o)
);

`default_nettype wire

/* csr_sys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_sys_top #(
    parameter int unsigned XLEN = rv_isa_pkg::XLEN_DEFAULT
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 stall_n_i,
    input  wire                 instr_valid_i,
    input  wire  [31:0]         instr_i,
    input  wire  [XLEN-1:0]     pc_i,
    input  wire  [XLEN-1:0]     csr_wdata_i,
    input  wire                 timer_int_i,
    output logic [XLEN-1:0]     csr_rdata_o,
    output logic                rdata_valid_o,
    output logic                redirect_o,
    output logic [XLEN-1:0]     redirect_pc_o
);

    // decode to CSR stage
    logic                d_valid;
    rv_isa_pkg::csr_op_e d_op;
    logic [11:0]         d_addr;
    logic [XLEN-1:0]     d_wdata;
    logic [XLEN-1:0]     d_pc;
    logic                d_ecall;
    logic                d_mret;

    // CSR stage to redirect
    logic                trap_take;
    logic                mret_take;
    logic [XLEN-1:0]     mtvec;
    logic [XLEN-1:0]     mepc;

    // redirect back to decode
    logic                flush;

    sys_decode #(
        .XLEN (XLEN)
    ) u_sys_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_n_i     (stall_n_i),
        .flush_i       (flush),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .csr_wdata_i   (csr_wdata_i),
        .valid_o       (d_valid),
        .op_o          (d_op),
        .addr_o        (d_addr),
        .wdata_o       (d_wdata),
        .pc_o          (d_pc),
        .ecall_o       (d_ecall),
        .mret_o        (d_mret)
    );

    csr_file #(
        .XLEN (XLEN)
    ) u_csr_file (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_n_i     (stall_n_i),
        .valid_i       (d_valid),
        .op_i          (d_op),
        .addr_i        (d_addr),
        .wdata_i       (d_wdata),
        .pc_i          (d_pc),
        .ecall_i       (d_ecall),
        .mret_i        (d_mret),
        .timer_int_i   (timer_int_i),
        .csr_rdata_o   (csr_rdata_o),
        .rdata_valid_o (rdata_valid_o),
        .trap_take_o   (trap_take),
        .mret_take_o   (mret_take),
        .mtvec_o       (mtvec),
        .mepc_o        (mepc)
    );

    trap_redirect #(
        .XLEN (XLEN)
    ) u_trap_redirect (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_n_i     (stall_n_i),
        .trap_take_i   (trap_take),
        .mret_take_i   (mret_take),
        .mtvec_i       (mtvec),
        .mepc_i        (mepc),
        .flush_o       (flush),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

`default_nettype wire

/* flist.f */
rv_isa_pkg.sv
rv_trap_pkg.sv
sys_decode.sv
csr_file.sv
trap_redirect.sv
csr_sys_top.sv
csr_sys_chk.sv
tb_csr_sys.sv

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // register width when the top level is left at its default
    localparam int unsigned XLEN_DEFAULT = 64;

    // major opcode, instr[6:2]
    localparam logic [4:0] OPC_SYSTEM = 5'b11100;

    // funct3 inside the SYSTEM opcode
    localparam logic [2:0] F3_PRIV  = 3'b000;
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_CSRRC = 3'b011;

    // imm[11:0] separates the privileged forms sharing F3_PRIV
    localparam logic [11:0] IMM_ECALL = 12'h000;
    localparam logic [11:0] IMM_MRET  = 12'h302;

    // machine mode CSR addresses
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MIE     = 12'h304;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;
    localparam logic [11:0] CSR_MIP     = 12'h344;

    // read-modify-write flavour carried from decode to the CSR stage
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_e;

endpackage

`default_nettype wire

/* rv_trap_pkg.sv */
`default_nettype none

package rv_trap_pkg;

    // mcause exception codes
    localparam int unsigned CAUSE_ECALL_M = 11;
    // interrupt code, the interrupt flag sits in the top bit of mcause
    localparam int unsigned CAUSE_TIMER_M = 7;

    // mstatus fields
    localparam int unsigned MSTATUS_MIE_BIT  = 3;
    localparam int unsigned MSTATUS_MPIE_BIT = 7;
    localparam int unsigned MSTATUS_MPP_LSB  = 11;

    // machine timer enable and pending
    localparam int unsigned MIE_MTIE_BIT = 7;
    localparam int unsigned MIP_MTIP_BIT = 7;

    // MPP = 2'b11, everything else cleared
    localparam logic [63:0] MSTATUS_RESET = 64'h0000_0000_0000_1800;

endpackage

`default_nettype wire

/* sys_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_decode #(
    parameter int unsigned XLEN = rv_isa_pkg::XLEN_DEFAULT
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     stall_n_i,
    input  wire                     flush_i,
    input  wire                     instr_valid_i,
    input  wire  [31:0]             instr_i,
    input  wire  [XLEN-1:0]         pc_i,
    input  wire  [XLEN-1:0]         csr_wdata_i,
    output logic                    valid_o,
    output rv_isa_pkg::csr_op_e     op_o,
    output logic [11:0]             addr_o,
    output logic [XLEN-1:0]         wdata_o,
    output logic [XLEN-1:0]         pc_o,
    output logic                    ecall_o,
    output logic                    mret_o
);

    logic [4:0]          opcode;
    logic [2:0]          funct3;
    logic [11:0]         imm;
    logic                is_system;
    logic                is_priv;
    logic                capture;
    rv_isa_pkg::csr_op_e op_dec;

    assign opcode = instr_i[6:2];
    assign funct3 = instr_i[14:12];
    assign imm    = instr_i[31:20];

    // only 32-bit encodings count as SYSTEM
    assign is_system = (instr_i[1:0] == 2'b11) && (opcode == rv_isa_pkg::OPC_SYSTEM);
    assign is_priv   = is_system && (funct3 == rv_isa_pkg::F3_PRIV);

    // a slot squashed by stage 3 never becomes valid
    assign capture = stall_n_i && instr_valid_i && !flush_i;

    always_comb begin
        op_dec = rv_isa_pkg::CSR_OP_NONE;
        if (is_system) begin
            case (funct3)
                rv_isa_pkg::F3_CSRRW: op_dec = rv_isa_pkg::CSR_OP_WRITE;
                rv_isa_pkg::F3_CSRRS: op_dec = rv_isa_pkg::CSR_OP_SET;
                rv_isa_pkg::F3_CSRRC: op_dec = rv_isa_pkg::CSR_OP_CLEAR;
                default:              op_dec = rv_isa_pkg::CSR_OP_NONE;
            endcase
        end
    end

    // non-SYSTEM instructions still occupy a valid slot, op stays none
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
            op_o    <= rv_isa_pkg::CSR_OP_NONE;
            ecall_o <= 1'b0;
            mret_o  <= 1'b0;
            pc_o    <= '0;
        end else if (stall_n_i) begin
            valid_o <= instr_valid_i && !flush_i;
            op_o    <= op_dec;
            ecall_o <= is_priv && (imm == rv_isa_pkg::IMM_ECALL);
            mret_o  <= is_priv && (imm == rv_isa_pkg::IMM_MRET);
            // pc of the last real slot, used as mepc by an interrupt on a bubble
            if (capture) begin
                pc_o <= pc_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            addr_o  <= imm;
            wdata_o <= csr_wdata_i;
        end
    end

endmodule

`default_nettype wire

/* tb_csr_sys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_sys;

    localparam int XLEN         = rv_isa_pkg::XLEN_DEFAULT;
    localparam int RESET_CYCLES = 16;
    localparam int N_OPS        = 40;
    // instructions per test: reset, ops, ecall, mret, timer, stall
    localparam int INSTR_COUNT  = 6 + (N_OPS + 3) + 8 + 4 + 10 + 6;
    localparam int MAX_CYCLES   = INSTR_COUNT * 4 + RESET_CYCLES + 200;

    localparam logic [6:0]      SYS_OPCODE  = {rv_isa_pkg::OPC_SYSTEM, 2'b11};
    localparam logic [11:0]     CSR_UNKNOWN = 12'h7c0;
    localparam logic [XLEN-1:0] MIE_MASK    = XLEN'(1) << rv_trap_pkg::MSTATUS_MIE_BIT;
    localparam logic [XLEN-1:0] MPIE_MASK   = XLEN'(1) << rv_trap_pkg::MSTATUS_MPIE_BIT;
    localparam logic [XLEN-1:0] MTIE_MASK   = XLEN'(1) << rv_trap_pkg::MIE_MTIE_BIT;
    localparam logic [XLEN-1:0] MTIP_MASK   = XLEN'(1) << rv_trap_pkg::MIP_MTIP_BIT;

    logic            clk;
    logic            rst_n;
    logic            stall_n_i;
    logic            instr_valid_i;
    logic [31:0]     instr_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] csr_wdata_i;
    logic            timer_int_i;
    logic [XLEN-1:0] csr_rdata_o;
    logic            rdata_valid_o;
    logic            redirect_o;
    logic [XLEN-1:0] redirect_pc_o;

    int cyc = 0;
    int errors;
    int passes;
    int seed;

    // reference CSR state
    logic [XLEN-1:0] m_mstatus;
    logic [XLEN-1:0] m_mie;
    logic [XLEN-1:0] m_mip;
    logic [XLEN-1:0] m_mtvec;
    logic [XLEN-1:0] m_mepc;
    logic [XLEN-1:0] m_mcause;
    logic [XLEN-1:0] last_pc;

    csr_sys_top #(
        .XLEN (XLEN)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_n_i     (stall_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .csr_wdata_i   (csr_wdata_i),
        .timer_int_i   (timer_int_i),
        .csr_rdata_o   (csr_rdata_o),
        .rdata_valid_o (rdata_valid_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    initial begin
        wait (cyc >= MAX_CYCLES);
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] addr);
        return {addr, 5'd1, f3, 5'd2, SYS_OPCODE};
    endfunction

    function automatic logic [31:0] priv_instr(input logic [11:0] imm);
        return {imm, 5'd0, rv_isa_pkg::F3_PRIV, 5'd0, SYS_OPCODE};
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [11:0] csr_addr(input int idx);
        case (idx)
            0:       return rv_isa_pkg::CSR_MSTATUS;
            1:       return rv_isa_pkg::CSR_MIE;
            2:       return rv_isa_pkg::CSR_MIP;
            3:       return rv_isa_pkg::CSR_MTVEC;
            4:       return rv_isa_pkg::CSR_MEPC;
            5:       return rv_isa_pkg::CSR_MCAUSE;
            default: return CSR_UNKNOWN;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] model_read(input logic [11:0] addr);
        case (addr)
            rv_isa_pkg::CSR_MSTATUS: return m_mstatus;
            rv_isa_pkg::CSR_MIE:     return m_mie;
            rv_isa_pkg::CSR_MIP:     return m_mip;
            rv_isa_pkg::CSR_MTVEC:   return m_mtvec;
            rv_isa_pkg::CSR_MEPC:    return m_mepc;
            rv_isa_pkg::CSR_MCAUSE:  return m_mcause;
            default:                 return '0;
        endcase
    endfunction

    task automatic model_csr(input logic [2:0] f3, input logic [11:0] addr,
                             input logic [XLEN-1:0] wdata);
        logic [XLEN-1:0] old_v;
        logic [XLEN-1:0] new_v;
        old_v = model_read(addr);
        case (f3)
            rv_isa_pkg::F3_CSRRW: new_v = wdata;
            rv_isa_pkg::F3_CSRRS: new_v = old_v | wdata;
            default:              new_v = old_v & ~wdata;
        endcase
        case (addr)
            rv_isa_pkg::CSR_MSTATUS: m_mstatus = new_v;
            rv_isa_pkg::CSR_MIE:     m_mie = new_v;
            rv_isa_pkg::CSR_MIP:     m_mip = new_v;
            rv_isa_pkg::CSR_MTVEC:   m_mtvec = new_v & ~XLEN'(3);
            rv_isa_pkg::CSR_MEPC:    m_mepc = new_v & ~XLEN'(3);
            rv_isa_pkg::CSR_MCAUSE:  m_mcause = new_v;
            default: begin
            end
        endcase
    endtask

    task automatic model_trap(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] cause);
        m_mepc = pc & ~XLEN'(3);
        m_mcause = cause;
        m_mstatus[rv_trap_pkg::MSTATUS_MPIE_BIT] = m_mstatus[rv_trap_pkg::MSTATUS_MIE_BIT];
        m_mstatus[rv_trap_pkg::MSTATUS_MIE_BIT] = 1'b0;
        m_mstatus[rv_trap_pkg::MSTATUS_MPP_LSB +: 2] = 2'b11;
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end else begin
            passes++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR at %0d ns: %s expected %b, got %b", $time, name, exp, act);
            errors++;
        end else begin
            passes++;
        end
    endtask

    task automatic check_latency(input string name, input int lat, input int exp);
        if (lat < 0) begin
            $display("at %0d ns: %s never went high after the instruction", $time, name);
            errors++;
        end else if (lat != exp) begin
            $display("ERROR at %0d ns: %s latency expected %0d, got %0d",
                     $time, name, exp, lat);
            errors++;
        end else begin
            passes++;
        end
    endtask

    task automatic issue(input logic [31:0] instr, input logic [XLEN-1:0] pc,
                         input logic [XLEN-1:0] wdata);
        @(negedge clk);
        stall_n_i = 1'b1;
        instr_valid_i = 1'b1;
        instr_i = instr;
        pc_i = pc;
        csr_wdata_i = wdata;
    endtask

    // idles the inputs, stalls the first cycles, then waits for the pulse
    task automatic wait_for(input logic on_redirect, input int t0, input int stall,
                            output int lat);
        int   i;
        logic seen;
        lat = -1;
        seen = 1'b0;
        i = 0;
        while (!seen && i < stall + 8) begin
            @(negedge clk);
            instr_valid_i = 1'b0;
            timer_int_i = 1'b0;
            stall_n_i = (i < stall) ? 1'b0 : 1'b1;
            seen = on_redirect ? redirect_o : rdata_valid_o;
            i++;
        end
        if (seen) begin
            lat = cyc - t0;
            @(negedge clk);
            check_bit(on_redirect ? "redirect_o" : "rdata_valid_o", 1'b0,
                      on_redirect ? redirect_o : rdata_valid_o);
        end
    endtask

    task automatic run_csr(input logic [2:0] f3, input logic [11:0] addr,
                           input logic [XLEN-1:0] wdata, input int stall);
        logic [XLEN-1:0] exp_old;
        logic [XLEN-1:0] pc;
        int              t0;
        int              lat;
        exp_old = model_read(addr);
        pc = rand_word();
        issue(csr_instr(f3, addr), pc, wdata);
        t0 = cyc;
        model_csr(f3, addr, wdata);
        last_pc = pc;
        wait_for(1'b0, t0, stall, lat);
        check_latency("rdata_valid_o", lat, 2 + stall);
        check_data("csr_rdata_o", exp_old, csr_rdata_o);
    endtask

    task automatic read_csr(input logic [11:0] addr);
        run_csr(rv_isa_pkg::F3_CSRRS, addr, '0, 0);
    endtask

    task automatic run_ecall(input logic with_victim, input int stall);
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        int              t0;
        int              lat;
        target = m_mtvec;
        pc = rand_word();
        issue(priv_instr(rv_isa_pkg::IMM_ECALL), pc, '0);
        t0 = cyc;
        model_trap(pc, XLEN'(rv_trap_pkg::CAUSE_ECALL_M));
        last_pc = pc;
        // younger csrrw on mie, killed by the flush
        if (with_victim) begin
            issue(csr_instr(rv_isa_pkg::F3_CSRRW, rv_isa_pkg::CSR_MIE), rand_word(), ~m_mie);
        end
        wait_for(1'b1, t0, stall, lat);
        check_latency("redirect_o", lat, 2 + stall);
        check_data("redirect_pc_o", target, redirect_pc_o);
        check_bit("rdata_valid_o", 1'b0, rdata_valid_o);
    endtask

    task automatic run_mret();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        int              t0;
        int              lat;
        target = m_mepc;
        pc = rand_word();
        issue(priv_instr(rv_isa_pkg::IMM_MRET), pc, '0);
        t0 = cyc;
        m_mstatus[rv_trap_pkg::MSTATUS_MIE_BIT] = m_mstatus[rv_trap_pkg::MSTATUS_MPIE_BIT];
        m_mstatus[rv_trap_pkg::MSTATUS_MPIE_BIT] = 1'b1;
        last_pc = pc;
        wait_for(1'b1, t0, 0, lat);
        check_latency("redirect_o", lat, 2);
        check_data("redirect_pc_o", target, redirect_pc_o);
    endtask

    task automatic report_test(input string name, input int err0);
        $display("test %s finished with %0d errors", name, errors - err0);
    endtask

    task automatic test_reset();
        int err0;
        int i;
        err0 = errors;
        for (i = 0; i < 6; i++) begin
            read_csr(csr_addr(i));
        end
        report_test("reset", err0);
    endtask

    task automatic test_csr_ops();
        int              err0;
        int              i;
        logic [11:0]     addr;
        logic [2:0]      f3;
        logic [XLEN-1:0] wdata;
        err0 = errors;
        for (i = 0; i < N_OPS; i++) begin
            addr = csr_addr($urandom % 7);
            case ($urandom % 3)
                0:       f3 = rv_isa_pkg::F3_CSRRW;
                1:       f3 = rv_isa_pkg::F3_CSRRS;
                default: f3 = rv_isa_pkg::F3_CSRRC;
            endcase
            wdata = rand_word();
            // mstatus.MIE stays clear so random mip bits cannot interrupt
            if (addr == rv_isa_pkg::CSR_MSTATUS && f3 != rv_isa_pkg::F3_CSRRC) begin
                wdata = wdata & ~MIE_MASK;
            end
            run_csr(f3, addr, wdata, 0);
        end
        run_csr(rv_isa_pkg::F3_CSRRW, rv_isa_pkg::CSR_MIP, '0, 0);
        run_csr(rv_isa_pkg::F3_CSRRW, rv_isa_pkg::CSR_MIE, '0, 0);
        run_csr(rv_isa_pkg::F3_CSRRW, rv_isa_pkg::CSR_MSTATUS, rv_trap_pkg::MSTATUS_RESET, 0);
        report_test("csr_ops", err0);
    endtask

    task automatic test_ecall();
        int err0;
        err0 = errors;
        run_csr(rv_isa_pkg::F3_CSRRW, rv_isa_pkg::CSR_MTVEC, rand_word(), 0);
        run_csr(rv_isa_pkg::F3_CSRRS, rv_isa_pkg::CSR_MSTATUS, MIE_MASK, 0);
        run_ecall(1'b1, 0);
        read_csr(rv_isa_pkg::CSR_MEPC);
        read_csr(rv_isa_pkg::CSR_MCAUSE);
        read_csr(rv_isa_pkg::CSR_MSTATUS);
        read_csr(rv_isa_pkg::CSR_MIE);
        report_test("ecall", err0);
    endtask

    task automatic test_mret();
        int err0;
        err0 = errors;
        run_csr(rv_isa_pkg::F3_CSRRW, rv_isa_pkg::CSR_MEPC, rand_word(), 0);
        run_csr(rv_isa_pkg::F3_CSRRW, rv_isa_pkg::CSR_MSTATUS,
                rv_trap_pkg::MSTATUS_RESET | MPIE_MASK, 0);
        run_mret();
        read_csr(rv_isa_pkg::CSR_MSTATUS);
        report_test("mret", err0);
    endtask

    task automatic test_timer();
        int              err0;
        int              t0;
        int              lat;
        logic [XLEN-1:0] target;
        err0 = errors;
        run_csr(rv_isa_pkg::F3_CSRRW, rv_isa_pkg::CSR_MTVEC, rand_word(), 0);
        run_csr(rv_isa_pkg::F3_CSRRS, rv_isa_pkg::CSR_MIE, MTIE_MASK, 0);
        run_csr(rv_isa_pkg::F3_CSRRS, rv_isa_pkg::CSR_MSTATUS, MIE_MASK, 0);
        target = m_mtvec;
        @(negedge clk);
        timer_int_i = 1'b1;
        t0 = cyc;
        m_mip = m_mip | MTIP_MASK;
        // no valid slot in stage 2, so mepc is the last captured pc
        model_trap(last_pc,
                   (XLEN'(1) << (XLEN - 1)) | XLEN'(rv_trap_pkg::CAUSE_TIMER_M));
        wait_for(1'b1, t0, 0, lat);
        check_latency("redirect_o", lat, 2);
        check_data("redirect_pc_o", target, redirect_pc_o);
        read_csr(rv_isa_pkg::CSR_MCAUSE);
        read_csr(rv_isa_pkg::CSR_MIP);
        read_csr(rv_isa_pkg::CSR_MSTATUS);
        run_csr(rv_isa_pkg::F3_CSRRC, rv_isa_pkg::CSR_MIP, MTIP_MASK, 0);
        // MIE was cleared by the trap, this pulse is ignored
        @(negedge clk);
        timer_int_i = 1'b1;
        t0 = cyc;
        wait_for(1'b1, t0, 0, lat);
        if (lat >= 0) begin
            $display("at %0d ns: redirect_o pulsed for a timer pulse with MIE clear", $time);
            errors++;
        end
        read_csr(rv_isa_pkg::CSR_MIP);
        report_test("timer", err0);
    endtask

    task automatic test_stall();
        int err0;
        err0 = errors;
        run_csr(rv_isa_pkg::F3_CSRRW, rv_isa_pkg::CSR_MEPC, rand_word(), 1 + $urandom % 5);
        run_csr(rv_isa_pkg::F3_CSRRS, rv_isa_pkg::CSR_MCAUSE, rand_word(), 1 + $urandom % 5);
        run_ecall(1'b0, 1 + $urandom % 5);
        read_csr(rv_isa_pkg::CSR_MEPC);
        read_csr(rv_isa_pkg::CSR_MCAUSE);
        read_csr(rv_isa_pkg::CSR_MSTATUS);
        report_test("stall", err0);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        stall_n_i = 1'b1;
        instr_valid_i = 1'b0;
        instr_i = '0;
        pc_i = '0;
        csr_wdata_i = '0;
        timer_int_i = 1'b0;
        errors = 0;
        passes = 0;
        seed = 32'hf823;
        void'($urandom(seed));
        m_mstatus = rv_trap_pkg::MSTATUS_RESET;
        m_mie = '0;
        m_mip = '0;
        m_mtvec = '0;
        m_mepc = '0;
        m_mcause = '0;
        last_pc = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_csr_ops();
        test_ecall();
        test_mret();
        test_timer();
        test_stall();
        $display("checks passed: %0d, errors: %0d", passes, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* trap_redirect.sv */
`timescale 1ns/1ps
`default_nettype none

module trap_redirect #(
    parameter int unsigned XLEN = rv_isa_pkg::XLEN_DEFAULT
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 stall_n_i,
    input  wire                 trap_take_i,
    input  wire                 mret_take_i,
    input  wire  [XLEN-1:0]     mtvec_i,
    input  wire  [XLEN-1:0]     mepc_i,
    output logic                flush_o,
    output logic                redirect_o,
    output logic [XLEN-1:0]     redirect_pc_o
);

    logic            take;
    logic [XLEN-1:0] target;

    assign take = trap_take_i || mret_take_i;

    // kill the younger slot sitting in decode
    assign flush_o = take;

    // trap wins, an interrupt already blocks the mret in stage 2
    assign target = trap_take_i ? mtvec_i : mepc_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_o <= 1'b0;
        end else begin
            // single cycle pulse, dropped while stalled
            redirect_o <= stall_n_i && take;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_pc_o <= '0;
        end else if (stall_n_i && take) begin
            redirect_pc_o <= target;
        end
    end

endmodule

`default_nettype wire
